// File: hdl/cdc_sync.sv
// Two-flop synchronizer into CLK_VIDEO
// Each bit is synchronized on its own, so a multi-bit payload must be
// quasi-static and only change when the receiver can tolerate a skewed update
`timescale 1ns/1ps

module cdc_sync #(
   parameter type payload_t = logic
) (
   input  logic     CLK_VIDEO,
   input  logic     rst_n,
   input  payload_t d,
   output payload_t q
);

   payload_t meta;

   always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
      if (!rst_n) begin
         meta <= '0;
         q    <= '0;
      end else begin
         meta <= d;
         q    <= meta;
      end
   end

endmodule

// File: hdl/msx_cfg_regs.sv
// APB slave holding the MSX control word and the command strobes
// Zero wait states, unmapped offsets return zero with pslverr set
// Command bits are self-clearing and never read back
`timescale 1ns/1ps
`include "msx_settings.svh"

module msx_cfg_regs (
   input  logic                          CLK_VIDEO,
   input  logic                          rst_n,
   // APB slave
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`MSX_APB_ADDR_W-1:0]    paddr,
   input  logic [`MSX_APB_DATA_W-1:0]    pwdata,
   output logic [`MSX_APB_DATA_W-1:0]    prdata,
   output logic                          pready,
   output logic                          pslverr,
   // Control fields
   output logic [1:0]                    aspect,
   output logic [1:0]                    scanlines,
   output logic [1:0]                    scale,
   output logic                          crop_en,
   output msx_pkg::tape_src_e            tape_src,
   output logic                          forced_sd,
   // Command strobes
   output logic                          soft_reset,
   output logic                          tape_rewind_cmd
);

   import msx_pkg::*;

   logic                        setup_phase;
   logic                        access_wr;
   logic                        addr_ctrl;
   logic                        addr_cmd;
   logic [`MSX_APB_DATA_W-1:0]  ctrl_q;
   logic [`MSX_APB_DATA_W-1:0]  rdata;

   assign setup_phase = psel && !penable;
   assign access_wr   = psel && penable && pwrite;
   assign addr_ctrl   = (paddr == `MSX_REG_CTRL);
   assign addr_cmd    = (paddr == `MSX_REG_CMD);

   // CMD and unmapped offsets both read as zero
   assign rdata  = addr_ctrl ? ctrl_q : '0;
   assign pready = 1'b1;

   // ============================================================
   // Read data and error, valid in the access phase
   // ============================================================
   always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
      if (!rst_n) begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end else begin
         prdata  <= (setup_phase && !pwrite) ? rdata : '0;
         pslverr <= setup_phase && !(addr_ctrl || addr_cmd);
      end
   end

   // ============================================================
   // Control word and command strobes
   // ============================================================
   always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q          <= '0;
         soft_reset      <= 1'b0;
         tape_rewind_cmd <= 1'b0;
      end else begin
         if (access_wr && addr_ctrl) begin
            ctrl_q <= pwdata & `MSX_CTRL_MASK;
         end
         // One cycle wide, right after the access phase
         soft_reset      <= access_wr && addr_cmd && pwdata[0];
         tape_rewind_cmd <= access_wr && addr_cmd && pwdata[1];
      end
   end

   // Field layout of the control word
   assign aspect    = ctrl_q[1:0];
   assign scanlines = ctrl_q[3:2];
   assign scale     = ctrl_q[5:4];
   assign crop_en   = ctrl_q[6];
   assign tape_src  = tape_src_e'(ctrl_q[7]);
   assign forced_sd = ctrl_q[8];

endmodule

// File: hdl/msx_core_ctrl.sv
// Core reset generation, tape rewind and cassette input select
// ADC pins are asynchronous and pass through a two-flop synchronizer
`timescale 1ns/1ps
`include "msx_settings.svh"

module msx_core_ctrl (
   input  logic               CLK_VIDEO,
   input  logic               rst_n,
   input  logic               ext_reset,
   input  logic               core_reset_req,
   input  logic               soft_reset,
   input  logic               tape_rewind_cmd,
   input  msx_pkg::tape_src_e tape_src,
   input  logic               cas_file_bit,
   input  logic               adc_dout,
   input  logic               adc_active,
   output logic               core_reset,
   output logic               tape_rewind,
   output logic               cas_audio_in
);

   import msx_pkg::*;

   localparam int CNT_W = $clog2(`MSX_RESET_STRETCH + 1);

   logic             reset_src;
   logic [CNT_W-1:0] stretch_cnt;
   adc_pair_t        adc_raw;
   adc_pair_t        adc_sync;

   assign reset_src      = soft_reset || ext_reset || core_reset_req;
   assign adc_raw.dout   = adc_dout;
   assign adc_raw.active = adc_active;

   cdc_sync #(
      .payload_t (adc_pair_t)
   ) u_adc_sync (
      .CLK_VIDEO (CLK_VIDEO),
      .rst_n     (rst_n),
      .d         (adc_raw),
      .q         (adc_sync)
   );

   // ============================================================
   // Reset stretch
   // ============================================================
   // Counter reloads while any source is high, reset falls when it empties
   always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
      if (!rst_n) begin
         stretch_cnt <= CNT_W'(`MSX_RESET_STRETCH - 1);
         core_reset  <= 1'b1;
         tape_rewind <= 1'b1;
      end else begin
         if (reset_src) begin
            stretch_cnt <= CNT_W'(`MSX_RESET_STRETCH - 1);
         end else if (stretch_cnt != '0) begin
            stretch_cnt <= stretch_cnt - 1'b1;
         end
         core_reset  <= reset_src || (stretch_cnt != '0);
         // Tape goes back to the start on any core reset
         tape_rewind <= tape_rewind_cmd || core_reset;
      end
   end

   // Cassette input, ADC bit only counts while a signal is present
   always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
      if (!rst_n) begin
         cas_audio_in <= 1'b0;
      end else begin
         cas_audio_in <= (tape_src == TAPE_FILE) ? cas_file_bit
                                                 : (adc_sync.dout && adc_sync.active);
      end
   end

endmodule

// File: hdl/msx_pkg.sv
// Shared types for the MSX video and cassette control logic
// HDMI sizes are 12 bits per axis as delivered by the framework
package msx_pkg;

   // ============================================================
   // Video geometry
   // ============================================================

   // HDMI output size, width in the upper half
   typedef struct packed {
      logic [11:0] width;
      logic [11:0] height;
   } hdmi_size_t;

   // Vertical crop in lines
   typedef logic [9:0] crop_t;

   // Aspect value, bit 12 selects scaled size and stays clear here
   typedef logic [12:0] ar_t;

   // ============================================================
   // Cassette
   // ============================================================

   typedef enum logic {
      TAPE_FILE = 1'b0,
      TAPE_ADC  = 1'b1
   } tape_src_e;

   // Comparator output and activity flag from the tape ADC
   typedef struct packed {
      logic dout;
      logic active;
   } adc_pair_t;

endpackage

// File: hdl/msx_settings.svh
// Register map, reset stretch and aspect constants for the MSX video control block
// APB data is 32 bits wide and only offsets 0 and 4 are decoded
`ifndef MSX_SETTINGS_SVH
`define MSX_SETTINGS_SVH

// APB register map
`define MSX_APB_ADDR_W      4
`define MSX_APB_DATA_W      32
`define MSX_REG_CTRL        4'h0
`define MSX_REG_CMD         4'h4
`define MSX_CTRL_MASK       32'h0000_01ff

// Core reset hold time after the last source drops, in clock cycles
`define MSX_RESET_STRETCH   16

// Original aspect numbers and the width threshold for the 4:3 high modes
`define MSX_AR_NARROW_X     400
`define MSX_AR_WIDE_X       340
`define MSX_AR_Y            300
`define MSX_HIGH_MIN_W      1440

`endif

// File: hdl/msx_video_ctrl_top.sv
// Top level of the MSX video and cassette control logic
// All blocks share CLK_VIDEO, HDMI size and ADC pins may be asynchronous
`timescale 1ns/1ps
`include "msx_settings.svh"

module msx_video_ctrl_top (
   input  logic                          CLK_VIDEO,
   input  logic                          rst_n,
   // APB slave
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`MSX_APB_ADDR_W-1:0]    paddr,
   input  logic [`MSX_APB_DATA_W-1:0]    pwdata,
   output logic [`MSX_APB_DATA_W-1:0]    prdata,
   output logic                          pready,
   output logic                          pslverr,
   // Video
   input  logic [11:0]                   hdmi_width,
   input  logic [11:0]                   hdmi_height,
   output msx_pkg::ar_t                  video_arx,
   output msx_pkg::ar_t                  video_ary,
   output msx_pkg::crop_t                crop_size,
   output logic [1:0]                    vga_sl,
   output logic [1:0]                    scale_sel,
   // Reset and cassette
   input  logic                          ext_reset,
   input  logic                          core_reset_req,
   input  logic                          cas_file_bit,
   input  logic                          adc_dout,
   input  logic                          adc_active,
   output logic                          core_reset,
   output logic                          tape_rewind,
   output logic                          cas_audio_in
);

   import msx_pkg::*;

   logic [1:0] aspect;
   logic [1:0] scanlines;
   logic [1:0] scale;
   logic       crop_en;
   tape_src_e  tape_src;
   logic       forced_sd;
   logic       soft_reset;
   logic       tape_rewind_cmd;

   msx_cfg_regs u_msx_cfg_regs (
      .CLK_VIDEO       (CLK_VIDEO),
      .rst_n           (rst_n),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .aspect          (aspect),
      .scanlines       (scanlines),
      .scale           (scale),
      .crop_en         (crop_en),
      .tape_src        (tape_src),
      .forced_sd       (forced_sd),
      .soft_reset      (soft_reset),
      .tape_rewind_cmd (tape_rewind_cmd)
   );

   video_geometry u_video_geometry (
      .CLK_VIDEO   (CLK_VIDEO),
      .rst_n       (rst_n),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .aspect      (aspect),
      .scanlines   (scanlines),
      .scale       (scale),
      .crop_en     (crop_en),
      .forced_sd   (forced_sd),
      .video_arx   (video_arx),
      .video_ary   (video_ary),
      .crop_size   (crop_size),
      .vga_sl      (vga_sl),
      .scale_sel   (scale_sel)
   );

   msx_core_ctrl u_msx_core_ctrl (
      .CLK_VIDEO       (CLK_VIDEO),
      .rst_n           (rst_n),
      .ext_reset       (ext_reset),
      .core_reset_req  (core_reset_req),
      .soft_reset      (soft_reset),
      .tape_rewind_cmd (tape_rewind_cmd),
      .tape_src        (tape_src),
      .cas_file_bit    (cas_file_bit),
      .adc_dout        (adc_dout),
      .adc_active      (adc_active),
      .core_reset      (core_reset),
      .tape_rewind     (tape_rewind),
      .cas_audio_in    (cas_audio_in)
   );

endmodule

// File: hdl/video_geometry.sv
// Vertical crop, wide flag and aspect outputs from the HDMI size
// HDMI size comes from another clock domain and must be quasi-static
// Crop is only applied without scandoubler, for the listed output heights
`timescale 1ns/1ps
`include "msx_settings.svh"

module video_geometry (
   input  logic              CLK_VIDEO,
   input  logic              rst_n,
   input  logic [11:0]       hdmi_width,
   input  logic [11:0]       hdmi_height,
   input  logic [1:0]        aspect,
   input  logic [1:0]        scanlines,
   input  logic [1:0]        scale,
   input  logic              crop_en,
   input  logic              forced_sd,
   output msx_pkg::ar_t      video_arx,
   output msx_pkg::ar_t      video_ary,
   output msx_pkg::crop_t    crop_size,
   output logic [1:0]        vga_sl,
   output logic [1:0]        scale_sel
);

   import msx_pkg::*;

   hdmi_size_t  size_raw;
   hdmi_size_t  size_sync;
   logic        scandoubler;
   logic [12:0] wide_min_w;
   crop_t       crop_raw;
   logic        wide;

   assign size_raw.width  = hdmi_width;
   assign size_raw.height = hdmi_height;

   cdc_sync #(
      .payload_t (hdmi_size_t)
   ) u_size_sync (
      .CLK_VIDEO (CLK_VIDEO),
      .rst_n     (rst_n),
      .d         (size_raw),
      .q         (size_sync)
   );

   assign scandoubler = forced_sd || (scanlines != 2'd0);
   // Width of at least 1.5 x height, one extra bit so it cannot wrap
   assign wide_min_w  = {1'b0, size_sync.height} + {2'b00, size_sync.height[11:1]};

   // ============================================================
   // Crop table
   // ============================================================
   always_comb begin
      crop_raw = '0;
      wide     = 1'b0;
      if (!scandoubler && ({1'b0, size_sync.width} >= wide_min_w)) begin
         case (size_sync.height)
            12'd480, 12'd720, 12'd1200: crop_raw = crop_t'(240);
            12'd600, 12'd800: begin
               crop_raw = crop_t'(200);
               wide     = crop_en;
            end
            // NTSC shows only 250 of these lines
            12'd768:  crop_raw = crop_t'(256);
            12'd1080: crop_raw = crop_t'(216);
            default:  crop_raw = '0;
         endcase
      end else if (!scandoubler && (size_sync.width >= 12'(`MSX_HIGH_MIN_W))) begin
         // 4:3 modes that miss the 1.5 ratio test
         case (size_sync.height)
            12'd1440: crop_raw = crop_t'(240);
            12'd1536: crop_raw = crop_t'(256);
            default:  crop_raw = '0;
         endcase
      end
   end

   // ============================================================
   // Output register
   // ============================================================
   always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
      if (!rst_n) begin
         video_arx <= '0;
         video_ary <= '0;
         crop_size <= '0;
         vga_sl    <= '0;
         scale_sel <= '0;
      end else begin
         crop_size <= crop_en ? crop_raw : '0;
         if (aspect == 2'd0) begin
            video_arx <= wide ? ar_t'(`MSX_AR_WIDE_X) : ar_t'(`MSX_AR_NARROW_X);
            video_ary <= ar_t'(`MSX_AR_Y);
         end else begin
            // Framework preset codes 0..2
            video_arx <= ar_t'(aspect) - ar_t'(1);
            video_ary <= '0;
         end
         vga_sl    <= scanlines;
         scale_sel <= scale;
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MSX video control testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_msx_video_ctrl
BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing -f sim.f --top-module "$TOP" -Mdir "$BUILD_DIR"; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
   echo "Testbench reported a failure, see $LOG"
   exit 1
fi

if [ "$run_status" -ne 0 ]; then
   echo "Simulator exited with status $run_status"
   exit 1
fi

echo "Run finished without failures"
exit 0

// File: sim.f
+incdir+hdl
hdl/msx_pkg.sv
hdl/cdc_sync.sv
hdl/msx_cfg_regs.sv
hdl/video_geometry.sv
hdl/msx_core_ctrl.sv
hdl/msx_video_ctrl_top.sv
verif/tb_msx_video_ctrl.sv

// File: verif/tb_msx_video_ctrl.sv
// Random self-checking testbench for the MSX video and cassette control block
// Inputs change on the rising edge and outputs are sampled on the falling edge
// Expected values come from a model of the control word, crop table and tape select
`timescale 1ns/1ps
`include "msx_settings.svh"

module tb_msx_video_ctrl;

   import msx_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;
   localparam int TABLE_H [9] = '{480, 600, 720, 768, 800, 1080, 1200, 1440, 1536};

   logic                       CLK_VIDEO;
   logic                       rst_n;
   logic                       psel;
   logic                       penable;
   logic                       pwrite;
   logic [`MSX_APB_ADDR_W-1:0] paddr;
   logic [31:0]                pwdata;
   logic [31:0]                prdata;
   logic                       pready;
   logic                       pslverr;
   logic [11:0]                hdmi_width;
   logic [11:0]                hdmi_height;
   ar_t                        video_arx;
   ar_t                        video_ary;
   crop_t                      crop_size;
   logic [1:0]                 vga_sl;
   logic [1:0]                 scale_sel;
   logic                       ext_reset;
   logic                       core_reset_req;
   logic                       cas_file_bit;
   logic                       adc_dout;
   logic                       adc_active;
   logic                       core_reset;
   logic                       tape_rewind;
   logic                       cas_audio_in;

   logic [31:0]                rng;
   logic [31:0]                ctrl_model;
   int                         error_count;
   int                         check_count;

   msx_video_ctrl_top u_msx_video_ctrl_top (
      .CLK_VIDEO      (CLK_VIDEO),
      .rst_n          (rst_n),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .hdmi_width     (hdmi_width),
      .hdmi_height    (hdmi_height),
      .video_arx      (video_arx),
      .video_ary      (video_ary),
      .crop_size      (crop_size),
      .vga_sl         (vga_sl),
      .scale_sel      (scale_sel),
      .ext_reset      (ext_reset),
      .core_reset_req (core_reset_req),
      .cas_file_bit   (cas_file_bit),
      .adc_dout       (adc_dout),
      .adc_active     (adc_active),
      .core_reset     (core_reset),
      .tape_rewind    (tape_rewind),
      .cas_audio_in   (cas_audio_in)
   );

   initial begin
      CLK_VIDEO = 1'b0;
      forever #4 CLK_VIDEO = ~CLK_VIDEO;
   end

   // ============================================================
   // Helpers
   // ============================================================
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stop_on_failure();
      $display("Simulation FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
      stop_on_failure();
   endtask

   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      int waited;
      @(posedge CLK_VIDEO);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge CLK_VIDEO);
      penable <= 1'b1;
      waited = 0;
      @(negedge CLK_VIDEO);
      while (!pready) begin
         waited++;
         if (waited > TIMEOUT_CYCLES) begin
            report_timeout("APB pready");
         end
         @(negedge CLK_VIDEO);
      end
      // Slave has no wait states
      check_value("APB wait states", 32'(waited), 32'd0);
      rdata = prdata;
      err   = pslverr;
      @(posedge CLK_VIDEO);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   // Length of the next core reset, rewind lags it by one cycle
   task automatic measure_reset_run(output int len);
      int waited;
      waited = 0;
      len    = 0;
      @(negedge CLK_VIDEO);
      while (!core_reset) begin
         waited++;
         if (waited > TIMEOUT_CYCLES) begin
            report_timeout("core_reset to rise");
         end
         @(negedge CLK_VIDEO);
      end
      while (core_reset) begin
         if (len > 0) begin
            check_value("tape_rewind during core reset", 32'(tape_rewind), 32'd1);
         end
         len++;
         if (len > TIMEOUT_CYCLES) begin
            report_timeout("core_reset to fall");
         end
         @(negedge CLK_VIDEO);
      end
      check_value("tape_rewind after core reset", 32'(tape_rewind), 32'd1);
   endtask

   task automatic measure_rewind_run(output int len);
      int waited;
      waited = 0;
      len    = 0;
      @(negedge CLK_VIDEO);
      while (!tape_rewind) begin
         waited++;
         if (waited > TIMEOUT_CYCLES) begin
            report_timeout("tape_rewind to rise");
         end
         @(negedge CLK_VIDEO);
      end
      while (tape_rewind) begin
         check_value("core_reset during rewind", 32'(core_reset), 32'd0);
         len++;
         if (len > TIMEOUT_CYCLES) begin
            report_timeout("tape_rewind to fall");
         end
         @(negedge CLK_VIDEO);
      end
   endtask

   // ============================================================
   // Reference model
   // ============================================================
   task automatic check_geometry();
      logic sd;
      logic ratio_ok;
      logic wide;
      int   w;
      int   h;
      int   raw;
      int   exp_arx;
      int   exp_ary;
      w        = int'(hdmi_width);
      h        = int'(hdmi_height);
      sd       = ctrl_model[8] || (ctrl_model[3:2] != 2'd0);
      ratio_ok = (2 * w >= 3 * h);
      raw      = 0;
      wide     = 1'b0;
      if (!sd && ratio_ok) begin
         if (h == 480 || h == 720 || h == 1200) raw = 240;
         if (h == 600 || h == 800) begin
            raw  = 200;
            wide = ctrl_model[6];
         end
         if (h == 768) raw = 256;
         if (h == 1080) raw = 216;
      end else if (!sd && w >= 1440) begin
         if (h == 1440) raw = 240;
         if (h == 1536) raw = 256;
      end
      if (ctrl_model[1:0] == 2'd0) begin
         exp_arx = wide ? 340 : 400;
         exp_ary = 300;
      end else begin
         exp_arx = int'(ctrl_model[1:0]) - 1;
         exp_ary = 0;
      end
      check_value("crop_size", 32'(crop_size), ctrl_model[6] ? 32'(raw) : 32'd0);
      check_value("video_arx", 32'(video_arx), 32'(exp_arx));
      check_value("video_ary", 32'(video_ary), 32'(exp_ary));
      check_value("vga_sl", 32'(vga_sl), 32'(ctrl_model[3:2]));
      check_value("scale_sel", 32'(scale_sel), 32'(ctrl_model[5:4]));
   endtask

   // ============================================================
   // Stimulus
   // ============================================================
   initial begin
      logic [31:0] rdata;
      logic [31:0] wdata;
      logic [3:0]  addr;
      logic        err;
      logic        exp_cas;
      int          len;
      int          w;
      int          h;
      rng            = 32'hac8a_02ba;
      ctrl_model     = 32'd0;
      error_count    = 0;
      check_count    = 0;
      rst_n          = 1'b0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = 32'd0;
      hdmi_width     = 12'd1920;
      hdmi_height    = 12'd1080;
      ext_reset      = 1'b0;
      core_reset_req = 1'b0;
      cas_file_bit   = 1'b0;
      adc_dout       = 1'b0;
      adc_active     = 1'b0;
      repeat (5) @(posedge CLK_VIDEO);
      rst_n <= 1'b1;

      // Reset values
      measure_reset_run(len);
      check_value("core_reset length after rst_n", 32'(len), 32'(`MSX_RESET_STRETCH));
      apb_access(1'b0, `MSX_REG_CTRL, 32'd0, rdata, err);
      check_value("CTRL after reset", rdata, 32'd0);
      check_value("pslverr on CTRL read", 32'(err), 32'd0);

      // Register map
      for (int i = 0; i < 20; i++) begin
         rng   = lcg_next(rng);
         wdata = rng;
         apb_access(1'b1, `MSX_REG_CTRL, wdata, rdata, err);
         check_value("pslverr on CTRL write", 32'(err), 32'd0);
         ctrl_model = wdata & `MSX_CTRL_MASK;
         apb_access(1'b0, `MSX_REG_CTRL, 32'd0, rdata, err);
         check_value("CTRL readback", rdata, ctrl_model);
         apb_access(1'b0, `MSX_REG_CMD, 32'd0, rdata, err);
         check_value("CMD readback", rdata, 32'd0);
         check_value("pslverr on CMD read", 32'(err), 32'd0);
         rng  = lcg_next(rng);
         addr = rng[27:24];
         if (addr == `MSX_REG_CTRL || addr == `MSX_REG_CMD) begin
            addr = addr ^ 4'h8;
         end
         apb_access(rng[12], addr, rng, rdata, err);
         check_value("pslverr on unmapped offset", 32'(err), 32'd1);
         check_value("prdata on unmapped offset", rdata, 32'd0);
      end
      apb_access(1'b0, `MSX_REG_CTRL, 32'd0, rdata, err);
      check_value("CTRL after unmapped writes", rdata, ctrl_model);

      // Video geometry with table heights and random sizes
      for (int i = 0; i < 40; i++) begin
         rng = lcg_next(rng);
         if (rng[31:30] != 2'b00) begin
            h = TABLE_H[int'(rng[23:16]) % 9];
         end else begin
            h = int'(rng[11:0]);
         end
         case (int'(rng[29:27]) % 5)
            0:       w = h * 16 / 9;
            1:       w = h * 4 / 3;
            2:       w = h * 3 / 2;
            3:       w = h * 3 / 2 - 1;
            default: w = int'(rng[15:4]);
         endcase
         if (w > 4095) w = 4095;
         if (w < 0) w = 0;
         @(posedge CLK_VIDEO);
         hdmi_width  <= 12'(w);
         hdmi_height <= 12'(h);
         rng   = lcg_next(rng);
         wdata = rng;
         // Half of the settings leave the scandoubler off
         if (rng[0]) begin
            wdata = wdata & ~32'h0000_010c;
         end
         apb_access(1'b1, `MSX_REG_CTRL, wdata, rdata, err);
         ctrl_model = wdata & `MSX_CTRL_MASK;
         repeat (5) @(posedge CLK_VIDEO);
         @(negedge CLK_VIDEO);
         check_geometry();
      end

      // Core reset sources
      apb_access(1'b1, `MSX_REG_CMD, 32'h0000_0001, rdata, err);
      measure_reset_run(len);
      check_value("core_reset length after soft reset", 32'(len), 32'(`MSX_RESET_STRETCH));
      for (int i = 0; i < 4; i++) begin
         rng = lcg_next(rng);
         @(posedge CLK_VIDEO);
         core_reset_req <= 1'b1;
         repeat (1 + int'(rng[17:16])) @(posedge CLK_VIDEO);
         core_reset_req <= 1'b0;
         measure_reset_run(len);
         check_value("core_reset length after request", 32'(len), 32'(`MSX_RESET_STRETCH));
      end

      // Rewind command alone
      apb_access(1'b1, `MSX_REG_CMD, 32'h0000_0002, rdata, err);
      measure_rewind_run(len);
      check_value("tape_rewind length", 32'(len), 32'd1);

      // Cassette input under both sources
      for (int i = 0; i < 32; i++) begin
         rng = lcg_next(rng);
         if (i % 8 == 0) begin
            wdata = (rng & ~32'h0000_0080) | {24'd0, i[3], 7'd0};
            apb_access(1'b1, `MSX_REG_CTRL, wdata, rdata, err);
            ctrl_model = wdata & `MSX_CTRL_MASK;
         end
         @(posedge CLK_VIDEO);
         cas_file_bit <= rng[21];
         adc_dout     <= rng[22];
         adc_active   <= rng[23];
         repeat (4) @(posedge CLK_VIDEO);
         @(negedge CLK_VIDEO);
         exp_cas = ctrl_model[7] ? (adc_dout && adc_active) : cas_file_bit;
         check_value("cas_audio_in", 32'(cas_audio_in), 32'(exp_cas));
      end

      if (error_count == 0) begin
         $display("%0d checks done", check_count);
         $display("Simulation PASSED");
         $finish;
      end else begin
         stop_on_failure();
      end
   end

endmodule
